// ==== hw/jamPkg.sv ====
`default_nettype none

package jamPkg;

    localparam int numAgents = 8;   // workers and jobs.
    localparam int agentW    = 3;
    localparam int costW     = 7;
    localparam int sumW      = 10;  // 8 x 127 fits.
    localparam int countW    = 16;  // wide enough for all 40320 orders.

    // one cost table address with the worker in the upper bits.
    typedef struct packed {
        logic [agentW-1:0] worker;
        logic [agentW-1:0] job;
    } assignPair_t;

    typedef struct packed {
        logic [sumW-1:0]   minCost;
        logic [countW-1:0] matchCount;
    } searchResult_t;

endpackage

`default_nettype wire

// ==== hw/costTable.sv ====
`default_nettype none

module costTable (
    input  logic                     CLK,
    input  logic                     loadEn,
    input  jamPkg::assignPair_t      loadPair,
    input  logic [jamPkg::costW-1:0] loadCost,
    input  logic                     lock,
    input  jamPkg::assignPair_t      readPair,
    output logic [jamPkg::costW-1:0] cost
);

    logic [jamPkg::costW-1:0] mem [jamPkg::numAgents*jamPkg::numAgents];

    always_ff @(posedge CLK)
    begin
        if (loadEn && !lock)  // table is frozen during a search.
        begin
            mem[{loadPair.worker, loadPair.job}] <= loadCost;
        end
        cost <= mem[{readPair.worker, readPair.job}];  // one cycle read latency.
    end

endmodule

`default_nettype wire

// ==== hw/permutationStepper.sv ====
`default_nettype none

module permutationStepper (
    input  logic                                        CLK,
    input  logic                                        RST,
    input  logic                                        restart,
    input  logic                                        stepReq,
    output logic                                        stepDone,
    output logic                                        lastPerm,
    output logic [jamPkg::numAgents*jamPkg::agentW-1:0] order
);

    typedef enum logic [1:0] {
        stIdle,
        stScan,
        stSwap,
        stReverse
    } stepState_t;

    stepState_t state;

    // element k is the job of worker k and worker 0 is the most significant place.
    logic [jamPkg::numAgents-1:0][jamPkg::agentW-1:0] arr;
    logic [jamPkg::numAgents-1:0][jamPkg::agentW-1:0] identity;
    logic [jamPkg::numAgents-1:0][jamPkg::agentW-1:0] reversed;
    logic [jamPkg::numAgents-2:0]                     ascent;
    logic [jamPkg::agentW-1:0]                        pivotIdx;
    logic [jamPkg::agentW-1:0]                        pivot;
    logic [jamPkg::agentW-1:0]                        partner;
    logic [jamPkg::agentW-1:0]                        scanPos;
    logic                                             found;

    assign order    = arr;
    assign lastPerm = ~|ascent;  // no ascent left means 7..0.

    always_comb
    begin
        for (int k = 0; k < jamPkg::numAgents; k++)
        begin
            identity[k] = jamPkg::agentW'(k);
        end
    end

    // neighbour compares where the highest set bit marks the pivot.
    always_comb
    begin
        for (int k = 0; k < jamPkg::numAgents - 1; k++)
        begin
            ascent[k] = arr[k] < arr[k+1];
        end
    end

    always_comb
    begin
        pivotIdx = '0;
        for (int k = 0; k < jamPkg::numAgents - 1; k++)
        begin
            if (ascent[k])
            begin
                pivotIdx = jamPkg::agentW'(k);  // later hits win.
            end
        end
    end

    // mirror the suffix behind the pivot.
    always_comb
    begin
        reversed = arr;
        for (int k = 0; k < jamPkg::numAgents; k++)
        begin
            if (k > pivot)
            begin
                reversed[k] = arr[jamPkg::numAgents + pivot - k];
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == stIdle && stepReq)
        begin
            pivot   <= pivotIdx;
            scanPos <= '1;  // start at the rightmost place.
            found   <= 1'b0;
        end
        else if (state == stScan)
        begin
            scanPos <= scanPos - 1'b1;
            // smallest element right of the pivot that still beats it.
            if (scanPos > pivot && arr[scanPos] > arr[pivot] &&
                (!found || arr[scanPos] < arr[partner]))
            begin
                partner <= scanPos;
                found   <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK or posedge RST)
    begin
        if (RST)
        begin
            state    <= stIdle;
            stepDone <= 1'b0;
            arr      <= identity;
        end
        else
        begin
            stepDone <= 1'b0;
            case (state)
                stIdle:
                begin
                    if (restart)
                    begin
                        arr <= identity;
                    end
                    else if (stepReq)
                    begin
                        state <= stScan;
                    end
                end
                stScan:
                begin
                    if (scanPos == jamPkg::agentW'(1))
                    begin
                        state <= stSwap;
                    end
                end
                stSwap:
                begin
                    arr[pivot]   <= arr[partner];
                    arr[partner] <= arr[pivot];
                    state        <= stReverse;
                end
                default:
                begin
                    arr      <= reversed;
                    stepDone <= 1'b1;  // order now holds the next permutation.
                    state    <= stIdle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/assignmentScan.sv ====
`default_nettype none

module assignmentScan (
    input  logic                                        CLK,
    input  logic                                        RST,
    input  logic                                        start,
    input  logic [jamPkg::numAgents*jamPkg::agentW-1:0] order,
    input  logic                                        lastPerm,
    input  logic                                        stepDone,
    output jamPkg::assignPair_t                         readPair,
    input  logic [jamPkg::costW-1:0]                    cost,
    output logic                                        stepReq,
    output logic                                        restart,
    output logic                                        busy,
    output logic                                        done,
    output jamPkg::searchResult_t                       result
);

    typedef enum logic [2:0] {
        stIdle,
        stRead,
        stTail,
        stCompare,
        stStep,
        stFinish
    } scanState_t;

    scanState_t                state;
    scanState_t                nextState;
    logic [jamPkg::agentW-1:0] worker;
    logic [jamPkg::sumW-1:0]   total;
    logic                      costValid;

    assign readPair.worker = worker;
    assign readPair.job    = order[worker*jamPkg::agentW +: jamPkg::agentW];

    assign busy    = state != stIdle;
    assign done    = state == stFinish;
    assign restart = state == stIdle && start;
    assign stepReq = state == stCompare && !lastPerm;

    always_comb
    begin
        nextState = state;
        case (state)
            stIdle:
                if (start)
                    nextState = stRead;
            stRead:
                if (worker == jamPkg::agentW'(jamPkg::numAgents - 1))
                    nextState = stTail;
            stTail:
                nextState = stCompare;  // last cost still in flight.
            stCompare:
                nextState = lastPerm ? stFinish : stStep;
            stStep:
                if (stepDone)
                    nextState = stRead;
            default:
                nextState = stIdle;
        endcase
    end

    always_ff @(posedge CLK or posedge RST)
    begin
        if (RST)
        begin
            state             <= stIdle;
            worker            <= '0;
            costValid         <= 1'b0;
            result.minCost    <= '1;
            result.matchCount <= '0;
        end
        else
        begin
            state     <= nextState;
            costValid <= state == stRead;  // table answers a cycle later.
            if (state == stRead)
            begin
                worker <= worker + 1'b1;
            end
            else
            begin
                worker <= '0;
            end
            if (restart)
            begin
                result.minCost    <= '1;
                result.matchCount <= '0;
            end
            else if (state == stCompare)
            begin
                if (total < result.minCost)
                begin
                    result.minCost    <= total;
                    result.matchCount <= jamPkg::countW'(1);
                end
                else if (total == result.minCost)
                begin
                    result.matchCount <= result.matchCount + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (nextState == stRead && state != stRead)
        begin
            total <= '0;  // fresh sum per permutation.
        end
        else if (costValid)
        begin
            total <= total + jamPkg::sumW'(cost);
        end
    end

endmodule

`default_nettype wire

// ==== hw/jamTop.sv ====
`default_nettype none

module jamTop (
    input  logic                     CLK,
    input  logic                     RST,
    input  logic                     loadEn,
    input  jamPkg::assignPair_t      loadPair,
    input  logic [jamPkg::costW-1:0] loadCost,
    input  logic                     start,
    output logic                     busy,
    output logic                     done,
    output jamPkg::searchResult_t    result
);

    jamPkg::assignPair_t                         readPair;
    logic [jamPkg::costW-1:0]                    cost;
    logic [jamPkg::numAgents*jamPkg::agentW-1:0] order;
    logic                                        lastPerm;
    logic                                        stepReq;
    logic                                        stepDone;
    logic                                        restart;

    costTable u_costTable (
        .CLK      (CLK),
        .loadEn   (loadEn),
        .loadPair (loadPair),
        .loadCost (loadCost),
        .lock     (busy),  // no table writes mid search.
        .readPair (readPair),
        .cost     (cost)
    );

    assignmentScan u_assignmentScan (
        .CLK      (CLK),
        .RST      (RST),
        .start    (start),
        .order    (order),
        .lastPerm (lastPerm),
        .stepDone (stepDone),
        .readPair (readPair),
        .cost     (cost),
        .stepReq  (stepReq),
        .restart  (restart),
        .busy     (busy),
        .done     (done),
        .result   (result)
    );

    permutationStepper u_permutationStepper (
        .CLK      (CLK),
        .RST      (RST),
        .restart  (restart),
        .stepReq  (stepReq),
        .stepDone (stepDone),
        .lastPerm (lastPerm),
        .order    (order)
    );

endmodule

`default_nettype wire

// ==== sim/jamClockGen.sv ====
`default_nettype none

module jamClockGen (
    output logic CLK,
    output logic RST
);

    initial
    begin
        CLK = 1'b0;
        RST = 1'b1;
        repeat (5) @(posedge CLK);
        @(negedge CLK);
        RST = 1'b0;  // released away from the active edge.
    end

    always
    begin
        #5 CLK = ~CLK;
    end

endmodule

`default_nettype wire

// ==== sim/jamTop_asserts.sv ====
`default_nettype none

module jamTop_asserts (
    input logic                  CLK,
    input logic                  RST,
    input logic                  start,
    input logic                  busy,
    input logic                  done,
    input jamPkg::searchResult_t result
);

    int failCount = 0;

    resetStateA: assert property (@(posedge CLK)
        $fell(RST) |-> !busy && !done && result.minCost == '1 && result.matchCount == '0)
    else
    begin
        failCount++;
        $error("outputs are not in their reset state after reset.");
    end

    donePulseA: assert property (@(posedge CLK) disable iff (RST) done |=> !done)
    else
    begin
        failCount++;
        $error("done stayed high for more than one cycle.");
    end

    doneInBusyA: assert property (@(posedge CLK) disable iff (RST) done |-> busy)
    else
    begin
        failCount++;
        $error("done came while busy was low.");
    end

    busyFallA: assert property (@(posedge CLK) disable iff (RST) done |=> !busy)
    else
    begin
        failCount++;
        $error("busy stayed high after done.");
    end

    busyEndA: assert property (@(posedge CLK) disable iff (RST) $fell(busy) |-> $past(done))
    else
    begin
        failCount++;
        $error("busy fell without a done pulse.");
    end

    startAcceptA: assert property (@(posedge CLK) disable iff (RST) start && !busy |=> busy)
    else
    begin
        failCount++;
        $error("a start while idle did not raise busy.");
    end

    // a second start mid search must not end or restart it.
    startIgnoredA: assert property (@(posedge CLK) disable iff (RST)
        start && busy && !done |=> busy)
    else
    begin
        failCount++;
        $error("a start during a search disturbed busy.");
    end

    resultHoldA: assert property (@(posedge CLK) disable iff (RST)
        !busy && !start |=> $stable(result))
    else
    begin
        failCount++;
        $error("result changed while the engine was idle.");
    end

endmodule

bind jamTop jamTop_asserts u_asserts (
    .CLK    (CLK),
    .RST    (RST),
    .start  (start),
    .busy   (busy),
    .done   (done),
    .result (result)
);

`default_nettype wire

// ==== sim/jamTb.sv ====
`default_nettype none

module jamTb;

    localparam int permCount  = 40320;
    localparam int numRuns    = 4;
    localparam int cycleLimit = numRuns * permCount * 22 + 10000;

    logic                     CLK;
    logic                     RST;
    logic                     loadEn;
    jamPkg::assignPair_t      loadPair;
    logic [jamPkg::costW-1:0] loadCost;
    logic                     start;
    logic                     busy;
    logic                     done;
    jamPkg::searchResult_t    result;

    logic [jamPkg::costW-1:0] costs [jamPkg::numAgents][jamPkg::numAgents];
    integer                   seed;
    int                       errCount;
    int                       cycleCount = 0;

    jamClockGen u_clockGen (
        .CLK (CLK),
        .RST (RST)
    );

    jamTop u_jamTop (
        .CLK      (CLK),
        .RST      (RST),
        .loadEn   (loadEn),
        .loadPair (loadPair),
        .loadCost (loadCost),
        .start    (start),
        .busy     (busy),
        .done     (done),
        .result   (result)
    );

    always @(posedge CLK)
    begin
        cycleCount++;
        if (cycleCount >= cycleLimit)
        begin
            $display("timeout: no search finished within %0d cycles.", cycleLimit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic checkValue(input string name, input int got, input int expected);
        assert (got == expected)
        else
        begin
            errCount++;
            $display("ERR %s: got %h, expected %h", name, got, expected);
        end
    endtask

    // walks all orders by single swaps and so does not follow lexicographic stepping.
    function automatic void referenceSearch(output int bestCost, output int bestCount);
        int perm [jamPkg::numAgents];
        int ctr [jamPkg::numAgents];
        int idx;
        int tmp;
        int total;
        bestCost  = 32'h7fffffff;
        bestCount = 0;
        for (int k = 0; k < jamPkg::numAgents; k++)
        begin
            perm[k] = k;
            ctr[k]  = 0;
        end
        idx = 1;
        do
        begin
            total = 0;
            for (int w = 0; w < jamPkg::numAgents; w++)
            begin
                total += costs[w][perm[w]];
            end
            if (total < bestCost)
            begin
                bestCost  = total;
                bestCount = 1;
            end
            else if (total == bestCost)
            begin
                bestCount++;
            end
            while (idx < jamPkg::numAgents && ctr[idx] >= idx)
            begin
                ctr[idx] = 0;
                idx++;
            end
            if (idx < jamPkg::numAgents)
            begin
                tmp = (idx % 2 == 0) ? 0 : ctr[idx];  // even index swaps with the head.
                {perm[tmp], perm[idx]} = {perm[idx], perm[tmp]};
                ctr[idx]++;
                idx = 1;
            end
        end
        while (idx < jamPkg::numAgents);
    endfunction

    task automatic fillRandom(input int lowest);
        for (int w = 0; w < jamPkg::numAgents; w++)
            for (int j = 0; j < jamPkg::numAgents; j++)
                costs[w][j] = jamPkg::costW'(lowest + $unsigned($random(seed)) % (128 - lowest));
    endtask

    task automatic loadTable;
        for (int w = 0; w < jamPkg::numAgents; w++)
        begin
            for (int j = 0; j < jamPkg::numAgents; j++)
            begin
                @(negedge CLK);
                loadEn          = 1'b1;
                loadPair.worker = jamPkg::agentW'(w);
                loadPair.job    = jamPkg::agentW'(j);
                loadCost        = costs[w][j];
            end
        end
        @(negedge CLK);
        loadEn = 1'b0;
    endtask

    task automatic runSearch(input bit disturb);
        @(negedge CLK);
        start = 1'b1;
        @(negedge CLK);
        start = 1'b0;
        checkValue("busy", busy, 1);
        if (disturb)
        begin
            for (int k = 0; k < jamPkg::numAgents * jamPkg::numAgents; k++)
            begin
                @(negedge CLK);
                loadEn   = 1'b1;
                loadPair = jamPkg::assignPair_t'(k);
                loadCost = '0;  // would pull the minimum down if it landed.
            end
            @(negedge CLK);
            loadEn = 1'b0;
            start  = 1'b1;
            @(negedge CLK);
            start = 1'b0;
        end
        while (!done)
        begin
            @(negedge CLK);
        end
    endtask

    task automatic checkResult(input int expMin, input int expCount);
        checkValue("result.minCost", result.minCost, expMin);
        checkValue("result.matchCount", result.matchCount, expCount);
    endtask

    task automatic checkAgainstReference;
        int bestCost;
        int bestCount;
        referenceSearch(bestCost, bestCount);
        checkResult(bestCost, bestCount);
    endtask

    initial
    begin
        loadEn   = 1'b0;
        loadPair = '0;
        loadCost = '0;
        start    = 1'b0;
        errCount = 0;
        seed     = 32'h4ca1;
        wait (RST === 1'b0);
        @(negedge CLK);
        checkValue("busy", busy, 0);
        checkValue("done", done, 0);
        checkResult(10'h3ff, 0);

        foreach (costs[w, j])
            costs[w][j] = 7'd127;  // every order costs the same.
        loadTable();
        runSearch(1'b0);
        checkResult(8 * 127, permCount);

        foreach (costs[w, j])
            costs[w][j] = (w == j) ? 7'd0 : 7'd100;
        loadTable();
        runSearch(1'b0);
        checkResult(0, 1);

        fillRandom(0);
        loadTable();
        runSearch(1'b0);
        checkAgainstReference();

        fillRandom(1);
        loadTable();
        runSearch(1'b1);
        checkAgainstReference();

        $display("errors: %0d in checks, %0d in assertions",
                 errCount, u_jamTop.u_asserts.failCount);
        if (errCount == 0 && u_jamTop.u_asserts.failCount == 0)
        begin
            $display("TESTS PASSED");
        end
        else
        begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
hw/jamPkg.sv
hw/costTable.sv
hw/permutationStepper.sv
hw/assignmentScan.sv
hw/jamTop.sv
sim/jamClockGen.sv
sim/jamTop_asserts.sv
sim/jamTb.sv

// ==== Bender.yml ====
package:
  name: jam_search

dependencies: {}

sources:
  - files:
      - hw/jamPkg.sv
      - hw/costTable.sv
      - hw/permutationStepper.sv
      - hw/assignmentScan.sv
      - hw/jamTop.sv
  - target: simulation
    files:
      - sim/jamClockGen.sv
      - sim/jamTop_asserts.sv
      - sim/jamTb.sv
